// File: verilog.f
qspi_pkg.sv
qspi_axil_slave.sv
qspi_sequencer.sv
qspi_phy.sv
qspi_ctrl_top.sv
qspi_mem_model.sv
qspi_ctrl_props.sv
tb_qspi_ctrl.sv

// File: Bender.yml
package:
  name: qspi_ctrl

sources:
  - qspi_pkg.sv
  - qspi_axil_slave.sv
  - qspi_sequencer.sv
  - qspi_phy.sv
  - qspi_ctrl_top.sv
  - target: test
    files:
      - qspi_mem_model.sv
      - qspi_ctrl_props.sv
      - tb_qspi_ctrl.sv

// File: tb_qspi_ctrl.sv
// testbench of the quad-SPI memory controller
// three memory models on the shared bus, a shadow memory per chip
// and a response checker fed by the reference model
`timescale 1ns/10ps
`default_nettype none

module tb_qspi_ctrl
	import qspi_pkg::*;
;

	localparam int TIMEOUT = 2000;
	localparam logic [11:0] PAGES [NUM_CS] = '{12'h3A5, 12'h2B4, 12'h187};

	typedef struct packed {
		logic       is_read;
		word_t      data;
		logic [1:0] resp;
	} exp_t;

	logic              clk;
	logic              rst_n;
	axil_req_t         axil_req;
	axil_rsp_t         axil_rsp;
	logic [1:0]        init_latency;
	logic              sck;
	logic [NUM_CS-1:0] ce_n;
	wire  [3:0]        sio;
	logic [NUM_CS-1:0] addr_err;
	latency_t          model_lat [NUM_CS];
	latency_t          exp_lat [NUM_CS];
	logic [7:0]        shadow [NUM_CS][4096];
	exp_t              exp_q [$];
	logic              pins_quiet;
	int                err_cnt = 0;

	qspi_ctrl_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.init_latency (init_latency),
		.sck          (sck),
		.ce_n         (ce_n),
		.sio          (sio)
	);

	for (genvar g = 0; g < NUM_CS; g++) begin : mem_g
		qspi_mem_model #(.PAGE(PAGES[g])) mem_i (
			.sck      (sck),
			.ce_n     (ce_n[g]),
			.latency  (model_lat[g]),
			.sio      (sio),
			.addr_err (addr_err[g])
		);
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic latency_t strap_latency(input logic [1:0] strap);
		case (strap)
			2'd0:    return 4'd7;
			2'd1:    return 4'd8;
			2'd2:    return 4'd9;
			default: return 4'd6;
		endcase
	endfunction

	function automatic logic [7:0] fill_byte(input logic [11:0] page, input logic [11:0] idx);
		return idx[7:0] ^ {2{idx[11:8]}} ^ page[7:0];
	endfunction

	function automatic logic [AXI_ADDR_W-1:0] mem_addr(input int cs, input int ofs);
		logic [11:0] page;
		page = (cs < NUM_CS) ? PAGES[cs] : 12'h000;
		return {2'b00, 2'(cs), page, 12'(ofs)};
	endfunction

	function automatic logic [AXI_ADDR_W-1:0] cfg_addr(input int ofs);
		return {1'b1, 27'(ofs)};
	endfunction

	function automatic logic [3:0] pick_strobe();
		case ($urandom % 8)
			0:       return 4'b1111;
			1:       return 4'b0011;
			2:       return 4'b1100;
			3:       return 4'b0001;
			4:       return 4'b0010;
			5:       return 4'b0100;
			6:       return 4'b1000;
			default: return 4'b1010;
		endcase
	endfunction

	// expected response from the shadow state and the address map
	function automatic exp_t ref_result(input logic is_read, input logic [AXI_ADDR_W-1:0] addr,
			input logic [3:0] strb);
		exp_t        e;
		int          cs;
		logic [11:0] base;
		e.is_read = is_read;
		e.data    = '0;
		e.resp    = 2'b10;
		cs        = addr[25:24];
		base      = {addr[11:2], 2'b00};
		if (addr[27]) begin
			if (addr[26:4] == '0 && addr[1:0] == 2'b00 && addr[3:2] != 2'd3) begin
				e.resp = 2'b00;
				if (is_read)
					e.data = 32'(exp_lat[addr[3:2]]);
			end
		end else if (cs != 3) begin
			if (is_read) begin
				e.resp = 2'b00;
				for (int i = 0; i < 4; i++)
					e.data[8*i +: 8] = shadow[cs][base + 12'(i)];
			end else begin
				case (strb)
					4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000:
						e.resp = 2'b00;
					default: e.resp = 2'b10;
				endcase
			end
		end
		return e;
	endfunction

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] expected);
		if (act !== expected) begin
			err_cnt++;
			$display("error at %0t: %s is %h, expected %h", $time, name, act, expected);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s within %0d cycles", what, TIMEOUT);
		$display("errors: %0d", err_cnt + 1);
		$display("Test failed");
		$finish;
	endtask

	task automatic wait_response(input logic is_read, input int delay);
		int n;
		n = 0;
		@(negedge clk);
		while (!(is_read ? axil_rsp.rvalid : axil_rsp.bvalid)) begin
			n++;
			if (n > TIMEOUT)
				stop_on_timeout("no response came back");
			@(negedge clk);
		end
		repeat (delay) @(negedge clk);
		@(posedge clk);
		#1;
		axil_req.rready = is_read;
		axil_req.bready = !is_read;
		@(posedge clk);
		#1;
		axil_req.rready = 1'b0;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input word_t data,
			input logic [3:0] strb, input int delay);
		int n;
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		n = 0;
		@(negedge clk);
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			n++;
			if (n > TIMEOUT)
				stop_on_timeout("awready and wready never rose for a write");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		wait_response(1'b0, delay);
	endtask

	task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, input int delay);
		int n;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		n = 0;
		@(negedge clk);
		while (!axil_rsp.arready) begin
			n++;
			if (n > TIMEOUT)
				stop_on_timeout("arready never rose for a read");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		axil_req.arvalid = 1'b0;
		wait_response(1'b1, delay);
	endtask

	task automatic apply_write(input logic [AXI_ADDR_W-1:0] addr, input word_t data,
			input logic [3:0] strb);
		if (addr[27]) begin
			if (strb[0])
				exp_lat[addr[3:2]] = data[3:0];
		end else begin
			for (int i = 0; i < 4; i++)
				if (strb[i])
					shadow[addr[25:24]][{addr[11:2], 2'(i)}] = data[8*i +: 8];
		end
	endtask

	task automatic issue_write(input logic [AXI_ADDR_W-1:0] addr, input word_t data,
			input logic [3:0] strb);
		exp_t e;
		e = ref_result(1'b0, addr, strb);
		exp_q.push_back(e);
		if (e.resp == 2'b00)
			apply_write(addr, data, strb);
		axil_write(addr, data, strb, $urandom % 4);
		// memory model follows the new latency once the bus is idle
		if (addr[27] && e.resp == 2'b00)
			model_lat[addr[3:2]] = exp_lat[addr[3:2]];
	endtask

	task automatic issue_read(input logic [AXI_ADDR_W-1:0] addr);
		exp_q.push_back(ref_result(1'b1, addr, 4'h0));
		axil_read(addr, $urandom % 4);
	endtask

	// response checker
	always @(negedge clk) begin
		exp_t e;
		if (rst_n && pins_quiet)
			check("ce_n", 32'(ce_n), 32'h7);
		if (rst_n && ((axil_rsp.bvalid && axil_req.bready) ||
				(axil_rsp.rvalid && axil_req.rready))) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("response handshake at %0t with no access outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				check("rvalid", 32'(axil_rsp.rvalid), 32'(e.is_read));
				check("bvalid", 32'(axil_rsp.bvalid), 32'(!e.is_read));
				if (e.is_read) begin
					check("rresp", 32'(axil_rsp.rresp), 32'(e.resp));
					if (e.resp == 2'b00)
						check("rdata", axil_rsp.rdata, e.data);
				end else begin
					check("bresp", 32'(axil_rsp.bresp), 32'(e.resp));
				end
			end
		end
	end

	initial begin
		int unsigned seed;
		int          op;
		int          cs;
		int          ofs;
		int          total;
		seed = 9989;
		void'($urandom(seed));
		axil_req     = '0;
		rst_n        = 1'b0;
		init_latency = 2'd1;
		pins_quiet   = 1'b0;
		for (int c = 0; c < NUM_CS; c++) begin
			model_lat[c] = strap_latency(init_latency);
			exp_lat[c]   = strap_latency(init_latency);
			for (int i = 0; i < 4096; i++)
				shadow[c][i] = fill_byte(PAGES[c], 12'(i));
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		check("ce_n", 32'(ce_n), 32'h7);
		check("sck", 32'(sck), 32'h1);
		check("arready", 32'(axil_rsp.arready), 32'h0);
		check("awready", 32'(axil_rsp.awready), 32'h0);
		check("wready", 32'(axil_rsp.wready), 32'h0);
		@(posedge clk);
		#1;
		rst_n = 1'b1;

		// idle pins and strap latency
		@(negedge clk);
		check("ce_n", 32'(ce_n), 32'h7);
		check("sck", 32'(sck), 32'h1);
		check("bvalid", 32'(axil_rsp.bvalid), 32'h0);
		check("rvalid", 32'(axil_rsp.rvalid), 32'h0);
		@(posedge clk);
		#1;
		for (int c = 0; c < NUM_CS; c++)
			issue_read(cfg_addr(4 * c));

		for (int c = 0; c < NUM_CS; c++) begin
			issue_write(mem_addr(c, 'h010), $urandom, 4'b1111);
			issue_write(mem_addr(c, 'hFFC), $urandom, 4'b1111);
			issue_read(mem_addr(c, 'h010));
			issue_read(mem_addr(c, 'hFFC));
		end

		// byte and halfword merges
		issue_write(mem_addr(1, 'h040), 32'h11223344, 4'b0001);
		issue_write(mem_addr(1, 'h040), 32'h55667788, 4'b0100);
		issue_write(mem_addr(1, 'h040), 32'h99AABBCC, 4'b1000);
		issue_write(mem_addr(1, 'h044), 32'hDEADBEEF, 4'b0011);
		issue_write(mem_addr(1, 'h044), 32'hCAFEF00D, 4'b1100);
		issue_write(mem_addr(1, 'h044), 32'h0000A500, 4'b0010);
		issue_read(mem_addr(1, 'h040));
		issue_read(mem_addr(1, 'h044));
		issue_write(mem_addr(2, 'h080), 32'h12345678, 4'b1100);
		issue_write(mem_addr(2, 'h080), 32'h9ABCDEF0, 4'b0010);
		issue_read(mem_addr(2, 'h080));

		// new latency in register and model
		issue_write(cfg_addr(0), 32'd3, 4'b1111);
		issue_write(cfg_addr(8), 32'd12, 4'b1111);
		issue_read(cfg_addr(0));
		issue_read(cfg_addr(8));
		issue_read(mem_addr(0, 'h010));
		issue_read(mem_addr(2, 'h010));

		// error responses with the bus idle
		pins_quiet = 1'b1;
		issue_write(mem_addr(0, 'h020), $urandom, 4'b0101);
		issue_write(mem_addr(0, 'h020), $urandom, 4'b0110);
		issue_write(mem_addr(3, 'h020), $urandom, 4'b1111);
		issue_read(mem_addr(3, 'h020));
		issue_read(cfg_addr('hC));
		issue_write(cfg_addr('h10), 32'd5, 4'b1111);
		pins_quiet = 1'b0;

		for (int n = 0; n < 200; n++) begin
			op  = $urandom % 10;
			cs  = $urandom % 3;
			ofs = ($urandom % 64) * 4;
			if (op < 4)
				issue_read(mem_addr(cs, ofs));
			else if (op < 8)
				issue_write(mem_addr(cs, ofs), $urandom, pick_strobe());
			else if (op == 8)
				issue_read(cfg_addr(4 * cs));
			else
				issue_write(cfg_addr(4 * cs), 1 + $urandom % 12, 4'b1111);
		end

		for (int c = 0; c < NUM_CS; c++)
			check("addr_err", 32'(addr_err[c]), 32'h0);
		check("pending responses", 32'(exp_q.size()), 32'h0);
		total = err_cnt + int'(dut_i.props_i.fail_cnt);
		$display("errors: %0d, assertion failures: %0d", err_cnt, dut_i.props_i.fail_cnt);
		if (total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: qspi_ctrl_props.sv
// pin and AXI4-Lite response rules of the quad-SPI controller
`timescale 1ns/10ps
`default_nettype none

module qspi_ctrl_props
	import qspi_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [NUM_CS-1:0] ce_n,
	input  logic              sio_oe,
	input  axil_req_t         axil_req,
	input  axil_rsp_t         axil_rsp
);

	int unsigned fail_cnt = 0;

	one_chip: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~ce_n) <= 1)
		else begin
			fail_cnt++;
			$error("more than one chip enable low");
		end

	// the bus is only driven towards a selected chip
	oe_needs_ce: assert property (@(posedge clk) disable iff (!rst_n)
		sio_oe |-> (ce_n != '1))
		else begin
			fail_cnt++;
			$error("sio driven with no chip selected");
		end

	b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else begin
			fail_cnt++;
			$error("write response dropped or changed before bready");
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.rvalid && !axil_req.rready |=>
		axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
		else begin
			fail_cnt++;
			$error("read response dropped or changed before rready");
		end

endmodule

bind qspi_ctrl_top qspi_ctrl_props props_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.ce_n     (ce_n),
	.sio_oe   (phy_i.oe_q),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp)
);

`default_nettype wire

// File: qspi_mem_model.sv
// behavioral quad-SPI memory for simulation
// answers Fast Read Quad and Quad Write on one chip enable,
// holds one 4 KiB page and flags accesses outside it
`timescale 1ns/10ps
`default_nettype none

module qspi_mem_model
	import qspi_pkg::*;
#(
	parameter logic [11:0] PAGE = 12'h000
) (
	input  wire        sck,
	input  wire        ce_n,
	input  latency_t   latency,
	inout  wire  [3:0] sio,
	output logic       addr_err
);

	logic [7:0]  mem [4096];
	logic [7:0]  cmd_q = 8'h00;
	flash_addr_t addr_q = '0;
	logic [3:0]  nib_q = 4'h0;
	int          rise_cnt = 0;
	logic        err_q = 1'b0;
	logic        drv_en = 1'b0;
	logic [3:0]  drv_val = 4'h0;

	initial begin
		for (int i = 0; i < 4096; i++)
			mem[i] = 8'(i) ^ {2{4'(i >> 8)}} ^ PAGE[7:0];
	end

	// command, address and write nibbles on the rising edge
	always @(posedge sck or posedge ce_n) begin
		int k;
		if (ce_n) begin
			rise_cnt = 0;
		end else begin
			k = rise_cnt - 14;
			if (rise_cnt < 8)
				cmd_q = {cmd_q[6:0], sio[0]};
			else if (rise_cnt < 14)
				addr_q = {addr_q[19:0], sio};
			else if (cmd_q == 8'h38) begin
				if (k % 2 == 0)
					nib_q = sio;
				else
					mem[addr_q[11:0] + 12'(k / 2)] = {nib_q, sio};
			end
			if (rise_cnt == 13 && addr_q[23:12] != PAGE)
				err_q = 1'b1;
			rise_cnt++;
		end
	end

	// read nibbles go out on the falling edge after the wait cycles
	always @(negedge sck or posedge ce_n) begin
		int         k;
		logic [7:0] b;
		k = rise_cnt - 14 - int'(latency);
		if (ce_n || cmd_q != 8'hEB || k < 0 || k > 7) begin
			drv_en = 1'b0;
		end else begin
			b       = mem[addr_q[11:0] + 12'(k / 2)];
			drv_val = (k % 2 == 0) ? b[7:4] : b[3:0];
			drv_en  = 1'b1;
		end
	end

	assign sio      = drv_en ? drv_val : 4'bzzzz;
	assign addr_err = err_q;

endmodule

`default_nettype wire

// File: qspi_ctrl_top.sv
// quad-SPI memory controller top level
// AXI4-Lite slave, transaction sequencer and pin layer
`timescale 1ns/10ps
`default_nettype none

module qspi_ctrl_top
	import qspi_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  axil_req_t         axil_req,
	output axil_rsp_t         axil_rsp,
	input  logic [1:0]        init_latency,
	output logic              sck,
	output logic [NUM_CS-1:0] ce_n,
	inout  wire  [3:0]        sio
);

	logic       seq_valid;
	logic       seq_ready;
	logic       seq_done;
	qspi_req_t  seq_req;
	word_t      seq_rdata;
	logic       sck_rise;
	logic       sck_fall;
	logic [3:0] sio_sync;
	pin_ctl_t   pin_ctl;

	qspi_axil_slave slave_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.init_latency (init_latency),
		.seq_valid    (seq_valid),
		.seq_req      (seq_req),
		.seq_ready    (seq_ready),
		.seq_done     (seq_done),
		.seq_rdata    (seq_rdata)
	);

	qspi_sequencer seq_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.seq_valid (seq_valid),
		.seq_req   (seq_req),
		.seq_ready (seq_ready),
		.seq_done  (seq_done),
		.seq_rdata (seq_rdata),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall),
		.sio_sync  (sio_sync),
		.pin_ctl   (pin_ctl)
	);

	qspi_phy phy_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.pin_ctl  (pin_ctl),
		.sck      (sck),
		.ce_n     (ce_n),
		.sck_rise (sck_rise),
		.sck_fall (sck_fall),
		.sio_sync (sio_sync),
		.sio      (sio)
	);

endmodule

`default_nettype wire

// File: qspi_phy.sv
// quad-SPI pin layer
// sck divider with edge strobes, registered pin drivers
// and a two-flop synchronizer on the sio inputs
`timescale 1ns/10ps
`default_nettype none

module qspi_phy
	import qspi_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  pin_ctl_t          pin_ctl,
	output logic              sck,
	output logic [NUM_CS-1:0] ce_n,
	output logic              sck_rise,
	output logic              sck_fall,
	output logic [3:0]        sio_sync,
	inout  wire  [3:0]        sio
);

	logic [$clog2(SCK_HALF)-1:0] div_q;
	logic                        sck_q;
	logic                        half_end;
	logic [NUM_CS-1:0]           ce_n_q;
	logic                        oe_q;
	logic [3:0]                  out_q;
	logic [3:0]                  sync1_q;
	logic [3:0]                  sync2_q;

	assign half_end = (int'(div_q) == SCK_HALF - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q <= '0;
			sck_q <= 1'b1;
		end else if (half_end) begin
			div_q <= '0;
			sck_q <= ~sck_q;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// strobes line up with the clk edge that flips sck
	assign sck_rise = half_end && !sck_q;
	assign sck_fall = half_end && sck_q;
	assign sck      = sck_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ce_n_q <= '1;
			oe_q   <= 1'b0;
		end else begin
			ce_n_q <= pin_ctl.cs_n;
			oe_q   <= pin_ctl.sio_oe;
		end
	end

	always_ff @(posedge clk) begin
		out_q <= pin_ctl.sio_out;
	end

	assign ce_n = ce_n_q;
	assign sio  = oe_q ? out_q : 4'bzzzz;

	always_ff @(posedge clk) begin
		sync1_q <= sio;
		sync2_q <= sync1_q;
	end

	assign sio_sync = sync2_q;

endmodule

`default_nettype wire

// File: qspi_sequencer.sv
// quad-SPI transaction sequencer
// sends command, address and write data, waits the read latency
// and collects read nibbles into a little-endian word
`timescale 1ns/10ps
`default_nettype none

module qspi_sequencer
	import qspi_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       seq_valid,
	input  qspi_req_t  seq_req,
	output logic       seq_ready,
	output logic       seq_done,
	output word_t      seq_rdata,
	input  logic       sck_rise,
	input  logic       sck_fall,
	input  logic [3:0] sio_sync,
	output pin_ctl_t   pin_ctl
);

	seq_state_e state_q;
	logic [3:0] cnt_q;
	qspi_req_t  req_q;
	word_t      shift_q;
	logic       take;
	logic       last;
	logic [3:0] data_len_m1;
	logic [2:0] wr_idx;
	logic [7:0] cmd_byte;
	logic       cmd_bit;
	logic [3:0] addr_nib;
	logic [3:0] wr_nib;

	// requests are only taken on an sck fall in idle
	assign seq_ready = (state_q == SEQ_IDLE) && sck_fall;
	assign take      = seq_valid && seq_ready;
	assign last      = (cnt_q == 4'd0);
	assign seq_done  = sck_fall && last &&
		((state_q == SEQ_WDATA) || (state_q == SEQ_RDATA));

	always_comb begin
		case (req_q.size)
			SIZE_BYTE: data_len_m1 = 4'd1;
			SIZE_HALF: data_len_m1 = 4'd3;
			default:   data_len_m1 = 4'd7;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= SEQ_IDLE;
			cnt_q   <= 4'd0;
		end else if (sck_fall) begin
			if (!last)
				cnt_q <= cnt_q - 4'd1;
			case (state_q)
				SEQ_IDLE: begin
					if (take) begin
						state_q <= SEQ_CMD;
						cnt_q   <= 4'd7;
					end
				end
				SEQ_CMD: begin
					if (last) begin
						state_q <= SEQ_ADDR;
						cnt_q   <= 4'd5;
					end
				end
				SEQ_ADDR: begin
					if (last) begin
						if (req_q.write) begin
							state_q <= SEQ_WDATA;
							cnt_q   <= data_len_m1;
						end else if (req_q.latency == '0) begin
							state_q <= SEQ_RDATA;
							cnt_q   <= 4'd7;
						end else begin
							// wait exactly latency sck cycles
							state_q <= SEQ_RWAIT;
							cnt_q   <= req_q.latency - 4'd1;
						end
					end
				end
				SEQ_RWAIT: begin
					if (last) begin
						state_q <= SEQ_RDATA;
						cnt_q   <= 4'd7;
					end
				end
				SEQ_WDATA, SEQ_RDATA: begin
					if (last)
						state_q <= SEQ_IDLE;
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			req_q <= seq_req;
	end

	// first nibble in ends up in the top bits
	always_ff @(posedge clk) begin
		if ((state_q == SEQ_RDATA) && sck_rise)
			shift_q <= {shift_q[27:0], sio_sync};
	end

	assign seq_rdata = {shift_q[7:0], shift_q[15:8], shift_q[23:16], shift_q[31:24]};

	assign cmd_byte = req_q.write ? CMD_WRITE_QUAD : CMD_READ_QUAD;
	assign cmd_bit  = cmd_byte[cnt_q[2:0]];
	assign addr_nib = req_q.addr[{cnt_q[2:0], 2'b00} +: 4];

	// lowest byte first, high nibble of each byte first
	assign wr_idx = data_len_m1[2:0] - cnt_q[2:0];
	assign wr_nib = req_q.wdata[{wr_idx[2:1], ~wr_idx[0], 2'b00} +: 4];

	always_comb begin
		pin_ctl.cs_n    = '1;
		pin_ctl.sio_oe  = 1'b0;
		pin_ctl.sio_out = 4'h0;
		if (state_q != SEQ_IDLE)
			pin_ctl.cs_n[req_q.cs] = 1'b0;
		case (state_q)
			SEQ_CMD: begin
				pin_ctl.sio_oe  = 1'b1;
				pin_ctl.sio_out = {3'b000, cmd_bit};
			end
			SEQ_ADDR: begin
				pin_ctl.sio_oe  = 1'b1;
				pin_ctl.sio_out = addr_nib;
			end
			SEQ_WDATA: begin
				pin_ctl.sio_oe  = 1'b1;
				pin_ctl.sio_out = wr_nib;
			end
			default: pin_ctl.sio_oe = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: qspi_axil_slave.sv
// AXI4-Lite slave of the quad-SPI controller
// decodes config and memory windows, keeps per-chip read latency
// and hands memory accesses to the sequencer one at a time
`timescale 1ns/10ps
`default_nettype none

module qspi_axil_slave
	import qspi_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  logic [1:0] init_latency,
	output logic       seq_valid,
	output qspi_req_t  seq_req,
	input  logic       seq_ready,
	input  logic       seq_done,
	input  word_t      seq_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_RESP
	} slv_state_e;

	slv_state_e state_q;
	logic       arready_q;
	logic       wready_q;
	logic       bvalid_q;
	logic       rvalid_q;
	logic [1:0] resp_q;
	word_t      rdata_q;
	latency_t   lat_q [NUM_CS];
	latency_t   lat_init;
	latency_t   sel_lat;
	word_t      cfg_rdata;
	logic       rd_acc;
	logic       wr_acc;
	logic       rd_cfg;
	logic       wr_cfg;
	logic       rd_cfg_ok;
	logic       wr_cfg_ok;
	cs_sel_t    rd_cs;
	cs_sel_t    wr_cs;
	logic       strb_ok;
	acc_size_t  wr_size;
	logic [1:0] wr_ofs;

	// latency registers at offsets 0, 4 and 8
	function automatic logic cfg_hit(input logic [AXI_ADDR_W-1:0] addr);
		return (addr[CFG_SEL_BIT-1:4] == '0) && (addr[1:0] == 2'b00) &&
			(int'(addr[3:2]) < NUM_CS);
	endfunction

	function automatic logic cs_ok(input cs_sel_t cs);
		return int'(cs) < NUM_CS;
	endfunction

	assign rd_acc    = arready_q && axil_req.arvalid;
	assign wr_acc    = wready_q && axil_req.awvalid && axil_req.wvalid;
	assign rd_cfg    = axil_req.araddr[CFG_SEL_BIT];
	assign wr_cfg    = axil_req.awaddr[CFG_SEL_BIT];
	assign rd_cfg_ok = rd_cfg && cfg_hit(axil_req.araddr);
	assign wr_cfg_ok = wr_cfg && cfg_hit(axil_req.awaddr);
	assign rd_cs     = axil_req.araddr[25:24];
	assign wr_cs     = axil_req.awaddr[25:24];

	always_comb begin
		case (init_latency)
			2'd0:    lat_init = LAT_INIT_0;
			2'd1:    lat_init = LAT_INIT_1;
			2'd2:    lat_init = LAT_INIT_2;
			default: lat_init = LAT_INIT_3;
		endcase
	end

	// size and lowest byte lane from the strobes
	always_comb begin
		strb_ok = 1'b1;
		wr_size = SIZE_BYTE;
		wr_ofs  = 2'd0;
		case (axil_req.wstrb)
			4'b1111: wr_size = SIZE_WORD;
			4'b0011: wr_size = SIZE_HALF;
			4'b1100: begin
				wr_size = SIZE_HALF;
				wr_ofs  = 2'd2;
			end
			4'b0001: wr_ofs = 2'd0;
			4'b0010: wr_ofs = 2'd1;
			4'b0100: wr_ofs = 2'd2;
			4'b1000: wr_ofs = 2'd3;
			default: strb_ok = 1'b0;
		endcase
	end

	always_comb begin
		cfg_rdata = '0;
		if (rd_cfg_ok)
			cfg_rdata = word_t'(lat_q[axil_req.araddr[3:2]]);
	end

	assign sel_lat = cs_ok(rd_cs) ? lat_q[rd_cs] : lat_q[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= ST_IDLE;
			arready_q <= 1'b0;
			wready_q  <= 1'b0;
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
			resp_q    <= RESP_OKAY;
			seq_valid <= 1'b0;
			for (int i = 0; i < NUM_CS; i++)
				lat_q[i] <= lat_init;
		end else begin
			arready_q <= 1'b0;
			wready_q  <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (rd_acc) begin
						if (!rd_cfg && cs_ok(rd_cs)) begin
							seq_valid <= 1'b1;
							state_q   <= ST_BUSY;
						end else begin
							rvalid_q <= 1'b1;
							resp_q   <= rd_cfg_ok ? RESP_OKAY : RESP_SLVERR;
							state_q  <= ST_RESP;
						end
					end else if (wr_acc) begin
						if (!wr_cfg && cs_ok(wr_cs) && strb_ok) begin
							seq_valid <= 1'b1;
							state_q   <= ST_BUSY;
						end else begin
							bvalid_q <= 1'b1;
							resp_q   <= wr_cfg_ok ? RESP_OKAY : RESP_SLVERR;
							state_q  <= ST_RESP;
							if (wr_cfg_ok && axil_req.wstrb[0])
								lat_q[axil_req.awaddr[3:2]] <= axil_req.wdata[3:0];
						end
					end else if (!arready_q && !wready_q) begin
						// reads win over a simultaneous write
						if (axil_req.arvalid)
							arready_q <= 1'b1;
						else if (axil_req.awvalid && axil_req.wvalid)
							wready_q <= 1'b1;
					end
				end
				ST_BUSY: begin
					if (seq_valid && seq_ready)
						seq_valid <= 1'b0;
					if (seq_done) begin
						resp_q   <= RESP_OKAY;
						bvalid_q <= seq_req.write;
						rvalid_q <= !seq_req.write;
						state_q  <= ST_RESP;
					end
				end
				ST_RESP: begin
					if ((bvalid_q && axil_req.bready) || (rvalid_q && axil_req.rready)) begin
						bvalid_q <= 1'b0;
						rvalid_q <= 1'b0;
						state_q  <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_acc) begin
			seq_req.write   <= 1'b0;
			seq_req.size    <= SIZE_WORD;
			seq_req.cs      <= rd_cs;
			seq_req.addr    <= {axil_req.araddr[23:2], 2'b00};
			seq_req.wdata   <= '0;
			seq_req.latency <= sel_lat;
			rdata_q         <= cfg_rdata;
		end else if (wr_acc) begin
			seq_req.write   <= 1'b1;
			seq_req.size    <= wr_size;
			seq_req.cs      <= wr_cs;
			seq_req.addr    <= {axil_req.awaddr[23:2], wr_ofs};
			seq_req.wdata   <= axil_req.wdata >> {wr_ofs, 3'b000};
			seq_req.latency <= sel_lat;
		end else if (seq_done && !seq_req.write) begin
			rdata_q <= seq_rdata;
		end
	end

	assign axil_rsp.awready = wready_q;
	assign axil_rsp.wready  = wready_q;
	assign axil_rsp.bresp   = resp_q;
	assign axil_rsp.bvalid  = bvalid_q;
	assign axil_rsp.arready = arready_q;
	assign axil_rsp.rdata   = rdata_q;
	assign axil_rsp.rresp   = resp_q;
	assign axil_rsp.rvalid  = rvalid_q;

endmodule

`default_nettype wire

// File: qspi_pkg.sv
// quad-SPI memory controller shared definitions
// bus structs, width types, command codes and sequencer states
`default_nettype none

package qspi_pkg;

	// sck runs at clk / (2 * SCK_HALF)
	localparam int SCK_HALF = 4;

	localparam logic [7:0] CMD_READ_QUAD  = 8'hEB;
	localparam logic [7:0] CMD_WRITE_QUAD = 8'h38;

	localparam int NUM_CS      = 3;
	localparam int AXI_ADDR_W  = 28;
	localparam int CFG_SEL_BIT = 27;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef logic [31:0] word_t;
	typedef logic [23:0] flash_addr_t;
	typedef logic [3:0]  latency_t;
	typedef logic [1:0]  cs_sel_t;
	typedef logic [1:0]  acc_size_t;

	localparam acc_size_t SIZE_BYTE = 2'd0;
	localparam acc_size_t SIZE_HALF = 2'd1;
	localparam acc_size_t SIZE_WORD = 2'd2;

	// latency reset values per strap setting
	localparam latency_t LAT_INIT_0 = 4'd7;
	localparam latency_t LAT_INIT_1 = 4'd8;
	localparam latency_t LAT_INIT_2 = 4'd9;
	localparam latency_t LAT_INIT_3 = 4'd6;

	typedef struct packed {
		logic [AXI_ADDR_W-1:0] awaddr;
		logic                  awvalid;
		word_t                 wdata;
		logic [3:0]            wstrb;
		logic                  wvalid;
		logic                  bready;
		logic [AXI_ADDR_W-1:0] araddr;
		logic                  arvalid;
		logic                  rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;
		logic       bvalid;
		logic       arready;
		word_t      rdata;
		logic [1:0] rresp;
		logic       rvalid;
	} axil_rsp_t;

	// one memory transaction, write data sits in the low bytes
	typedef struct packed {
		logic        write;
		acc_size_t   size;
		cs_sel_t     cs;
		flash_addr_t addr;
		word_t       wdata;
		latency_t    latency;
	} qspi_req_t;

	typedef struct packed {
		logic [NUM_CS-1:0] cs_n;
		logic              sio_oe;
		logic [3:0]        sio_out;
	} pin_ctl_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_CMD,
		SEQ_ADDR,
		SEQ_WDATA,
		SEQ_RWAIT,
		SEQ_RDATA
	} seq_state_e;

endpackage

`default_nettype wire
